//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Mdir obj_dir
TOP       = trace_top_tb
FILELIST  = rv_trace.f
LOG       = sim.log

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- capture/ex_capture.sv
/*
  occupancy lives in trace_ctrl, this slot only sees load and handoff
  only the first granted access of a record is kept
*/
`timescale 1ns/1ps
`default_nettype none

module ex_capture #(
  parameter int unsigned CYCLE_WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_ex,
  input  logic                   advance_ex,
  input  trace_pkg::dec_info_t   dec,
  input  rv_isa_pkg::word_t      pc,
  input  rv_isa_pkg::word_t      instr,
  input  rv_isa_pkg::word_t      rs1_value,
  input  rv_isa_pkg::word_t      rs2_value,
  input  logic [CYCLE_WIDTH-1:0] cycle_count,
  input  trace_pkg::reg_write_t  ex_reg,
  input  trace_pkg::mem_req_t    ex_data,
  output trace_pkg::trace_rec_t  ex_rec,
  output logic [CYCLE_WIDTH-1:0] ex_cycle
);
  import trace_pkg::*;

  trace_rec_t slot_q;
  trace_rec_t slot_upd;
  trace_rec_t slot_new;
  trace_rec_t slot_idle;

  // this edge's EX write and grant folded in
  always_comb begin
    slot_upd = merge_rd(slot_q, ex_reg);
    if (!slot_q.mem_obs.valid && ex_data.req && ex_data.gnt) begin
      slot_upd.mem_obs.valid = 1'b1;
      slot_upd.mem_obs.we    = ex_data.we;
      slot_upd.mem_obs.addr  = ex_data.addr;
    end
  end

  assign ex_rec = slot_upd;

  always_comb begin
    slot_new           = '0;
    slot_new.pc        = pc;
    slot_new.instr     = instr;
    slot_new.dec       = dec;
    slot_new.rs1_value = rs1_value;
    slot_new.rs2_value = rs2_value;
  end

  // empty slot reads clean after handoff
  always_comb begin
    slot_idle         = slot_q;
    slot_idle.rd_seen = 1'b0;
    slot_idle.mem_obs = '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_q <= '0;
    end else if (load_ex) begin
      slot_q <= slot_new;
    end else if (advance_ex) begin
      slot_q <= slot_idle;
    end else begin
      slot_q <= slot_upd;
    end
  end

  always_ff @(posedge clk) begin
    if (load_ex) begin
      ex_cycle <= cycle_count;
    end
  end

  a_mem_obs_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    slot_q.mem_obs.valid && !load_ex && !advance_ex |=> $stable(slot_q.mem_obs));

endmodule

`default_nettype wire

//--- capture/wb_capture.sv
/*
  trace_rec and trace_cycle are valid only while trace_valid is high
*/
`timescale 1ns/1ps
`default_nettype none

module wb_capture #(
  parameter int unsigned CYCLE_WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   advance_ex,
  input  logic                   emit_wb,
  input  trace_pkg::trace_rec_t  ex_rec,
  input  logic [CYCLE_WIDTH-1:0] ex_cycle,
  input  trace_pkg::reg_write_t  wb_reg,
  output logic                   trace_valid,
  output trace_pkg::trace_rec_t  trace_rec,
  output logic [CYCLE_WIDTH-1:0] trace_cycle
);
  import trace_pkg::*;

  trace_rec_t             slot_q;
  trace_rec_t             slot_upd;
  logic [CYCLE_WIDTH-1:0] cycle_q;

  assign slot_upd = merge_rd(slot_q, wb_reg);

  // a write on the handoff edge belongs to the old occupant
  always_ff @(posedge clk) begin
    if (advance_ex) begin
      slot_q  <= ex_rec;
      cycle_q <= ex_cycle;
    end else begin
      slot_q  <= slot_upd;
    end
    if (emit_wb) begin
      trace_rec   <= slot_upd;
      trace_cycle <= cycle_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= emit_wb;
    end
  end

  a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    trace_valid && $past(trace_valid) |-> $past(emit_wb) && $past(emit_wb, 2));

endmodule

`default_nettype wire

//--- common/rv_isa_pkg.sv
/*
  base RV32I encoding only, no compressed or custom opcodes
*/
`default_nettype none

package rv_isa_pkg;

  parameter int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // lsb positions of the fixed fields in a 32-bit word
  parameter int unsigned RD_LSB     = 7;
  parameter int unsigned FUNCT3_LSB = 12;
  parameter int unsigned RS1_LSB    = 15;
  parameter int unsigned RS2_LSB    = 20;

  // major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_branch   = 7'b1100011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_misc_mem = 7'b0001111,
    opc_system   = 7'b1110011
  } opcode_e;

endpackage

`default_nettype wire

//--- common/trace_pkg.sv
/*
  record layout of the retirement trace
  rd_value and mem_obs are only meaningful with rd_seen or mem_obs.valid set
*/
`default_nettype none

package trace_pkg;

  typedef enum logic [3:0] {
    cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_load, cls_store,
    cls_op_imm, cls_op, cls_fence, cls_csr, cls_sys, cls_invalid
  } instr_class_e;

  typedef enum logic {
    st_idle,
    st_armed
  } ctrl_state_e;

  typedef struct packed {
    instr_class_e          cls;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    logic                  rd_used;
    logic                  rs1_used;
    logic                  rs2_used;
  } dec_info_t;

  typedef struct packed {
    logic                  we;
    rv_isa_pkg::reg_addr_t addr;
    rv_isa_pkg::word_t     wdata;
  } reg_write_t;

  typedef struct packed {
    logic              req;
    logic              gnt;
    logic              we;
    rv_isa_pkg::word_t addr;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    rv_isa_pkg::word_t addr;
  } mem_obs_t;

  typedef struct packed {
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t instr;
    dec_info_t         dec;
    rv_isa_pkg::word_t rs1_value;
    rv_isa_pkg::word_t rs2_value;
    logic              rd_seen;
    rv_isa_pkg::word_t rd_value;
    mem_obs_t          mem_obs;
  } trace_rec_t;

  // shared by the EX and WB slots
  function automatic trace_rec_t merge_rd(trace_rec_t rec, reg_write_t wr);
    trace_rec_t res;
    res = rec;
    if (wr.we && rec.dec.rd_used && (wr.addr == rec.dec.rd)) begin
      res.rd_seen  = 1'b1;
      res.rd_value = wr.wdata;
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- decode/instr_classify.sv
/*
  funct7 is not checked, so M-extension OP words classify as cls_op
*/
`timescale 1ns/1ps
`default_nettype none

module instr_classify (
  input  rv_isa_pkg::word_t    instr,
  output trace_pkg::dec_info_t dec
);
  import rv_isa_pkg::*;
  import trace_pkg::*;

  opcode_e      opc;
  logic [2:0]   funct3;
  reg_addr_t    rd;
  reg_addr_t    rs1;
  reg_addr_t    rs2;
  instr_class_e cls;

  assign opc    = opcode_e'(instr[$bits(opcode_e)-1:0]);
  assign funct3 = instr[FUNCT3_LSB +: 3];
  assign rd     = instr[RD_LSB +: $bits(reg_addr_t)];
  assign rs1    = instr[RS1_LSB +: $bits(reg_addr_t)];
  assign rs2    = instr[RS2_LSB +: $bits(reg_addr_t)];

  ////////////////////
  // class decode
  ////////////////////
  always_comb begin
    cls = cls_invalid;
    case (opc)
      opc_lui:    cls = cls_lui;
      opc_auipc:  cls = cls_auipc;
      opc_jal:    cls = cls_jal;
      opc_jalr: begin
        if (funct3 == 3'b000) begin
          cls = cls_jalr;
        end
      end
      // funct3 010 and 011 are unused for branches
      opc_branch: begin
        if (funct3[2:1] != 2'b01) begin
          cls = cls_branch;
        end
      end
      opc_load: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          cls = cls_load;
        end
      end
      opc_store: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          cls = cls_store;
        end
      end
      opc_op_imm: cls = cls_op_imm;
      opc_op:     cls = cls_op;
      // fence and fence.i
      opc_misc_mem: begin
        if (funct3[2:1] == 2'b00) begin
          cls = cls_fence;
        end
      end
      opc_system: begin
        if (funct3 == 3'b000) begin
          cls = cls_sys;
        end else if (funct3 != 3'b100) begin
          cls = cls_csr;
        end
      end
      default: cls = cls_invalid;
    endcase
  end

  ////////////////////
  // register usage
  ////////////////////
  always_comb begin
    dec.cls      = cls;
    dec.rd       = rd;
    dec.rs1      = rs1;
    dec.rs2      = rs2;
    // x0 writes are never tracked
    dec.rd_used  = (cls inside {cls_lui, cls_auipc, cls_jal, cls_jalr, cls_load,
                                cls_op_imm, cls_op, cls_csr}) && (rd != '0);
    // csr immediate forms reuse the rs1 field as zimm
    dec.rs1_used = (cls inside {cls_jalr, cls_branch, cls_load, cls_store,
                                cls_op_imm, cls_op}) ||
                   ((cls == cls_csr) && !funct3[2]);
    dec.rs2_used = cls inside {cls_branch, cls_store, cls_op};
  end

endmodule

`default_nettype wire

//--- dv/trace_top_tb.sv
/*
  random stimulus from a fixed xorshift seed, checked against a slot model
  outputs are sampled and inputs driven 1 ns after each rising edge
*/
`timescale 1ns/1ps
`default_nettype none

module trace_top_tb;
  import rv_isa_pkg::*;
  import trace_pkg::*;

  localparam int CYCLE_WIDTH  = 32;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_CYCLES   = 3000;
  localparam int ARM_CYCLE    = 40;
  localparam int BURST_CYCLE  = 2400;
  localparam int MARGIN       = 50;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   fetch_enable;
  word_t                  pc;
  word_t                  instr;
  logic                   id_valid;
  logic                   is_decoding;
  logic                   pipe_flush;
  word_t                  rs1_value;
  word_t                  rs2_value;
  logic                   ex_valid;
  reg_write_t             ex_reg;
  mem_req_t               ex_data;
  logic                   wb_valid;
  reg_write_t             wb_reg;
  logic                   trace_valid;
  trace_rec_t             trace_rec;
  logic [CYCLE_WIDTH-1:0] trace_cycle;
  logic                   trace_overflow;

  // reference model state
  logic                   m_armed;
  logic                   m_ex_occ;
  logic                   m_wb_occ;
  logic                   m_ovf;
  trace_rec_t             m_ex;
  trace_rec_t             m_wb;
  logic [CYCLE_WIDTH-1:0] m_ex_cyc;
  logic [CYCLE_WIDTH-1:0] m_wb_cyc;
  logic [CYCLE_WIDTH-1:0] m_cycle;
  trace_rec_t             exp_q[$];
  logic [CYCLE_WIDTH-1:0] exp_cyc_q[$];

  logic [31:0] rng;
  int          value_errors = 0;
  int          other_errors = 0;
  int          n_emitted = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  trace_top #(.CYCLE_WIDTH(CYCLE_WIDTH)) trace_top_inst (
    .clk(clk), .rst_n(rst_n), .fetch_enable(fetch_enable), .pc(pc), .instr(instr),
    .id_valid(id_valid), .is_decoding(is_decoding), .pipe_flush(pipe_flush),
    .rs1_value(rs1_value), .rs2_value(rs2_value), .ex_valid(ex_valid),
    .ex_reg(ex_reg), .ex_data(ex_data), .wb_valid(wb_valid), .wb_reg(wb_reg),
    .trace_valid(trace_valid), .trace_rec(trace_rec), .trace_cycle(trace_cycle),
    .trace_overflow(trace_overflow)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // 15 of 16 codes hit listed opcodes and one is illegal
  function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
    case (sel)
      4'd0:    return opc_lui;
      4'd1:    return opc_auipc;
      4'd2:    return opc_jal;
      4'd3:    return opc_jalr;
      4'd4:    return opc_branch;
      4'd5:    return opc_load;
      4'd6:    return opc_store;
      4'd7:    return opc_op;
      4'd8:    return opc_misc_mem;
      4'd9:    return opc_system;
      4'd10:   return 7'b1011011;
      default: return opc_op_imm;
    endcase
  endfunction

  ////////////////////
  // reference model
  ////////////////////
  function automatic dec_info_t classify(input word_t w);
    dec_info_t  d;
    logic [2:0] f3;
    f3    = w[14:12];
    d     = '0;
    d.rd  = w[11:7];
    d.rs1 = w[19:15];
    d.rs2 = w[24:20];
    case (w[6:0])
      opc_lui:      d.cls = cls_lui;
      opc_auipc:    d.cls = cls_auipc;
      opc_jal:      d.cls = cls_jal;
      opc_jalr:     d.cls = (f3 == 3'd0) ? cls_jalr : cls_invalid;
      opc_branch:   d.cls = (f3 == 3'd2 || f3 == 3'd3) ? cls_invalid : cls_branch;
      opc_load:     d.cls = (f3 == 3'd3 || f3 >= 3'd6) ? cls_invalid : cls_load;
      opc_store:    d.cls = (f3 <= 3'd2) ? cls_store : cls_invalid;
      opc_op_imm:   d.cls = cls_op_imm;
      opc_op:       d.cls = cls_op;
      opc_misc_mem: d.cls = (f3 <= 3'd1) ? cls_fence : cls_invalid;
      opc_system:   d.cls = (f3 == 3'd0) ? cls_sys : (f3 == 3'd4) ? cls_invalid : cls_csr;
      default:      d.cls = cls_invalid;
    endcase
    case (d.cls)
      cls_lui, cls_auipc, cls_jal: d.rd_used = 1'b1;
      cls_jalr, cls_load, cls_op_imm: begin
        d.rd_used  = 1'b1;
        d.rs1_used = 1'b1;
      end
      cls_branch, cls_store: begin
        d.rs1_used = 1'b1;
        d.rs2_used = 1'b1;
      end
      cls_op: begin
        d.rd_used  = 1'b1;
        d.rs1_used = 1'b1;
        d.rs2_used = 1'b1;
      end
      cls_csr: begin
        d.rd_used  = 1'b1;
        d.rs1_used = !f3[2];
      end
      default: d.rd_used = 1'b0;
    endcase
    d.rd_used = d.rd_used && (d.rd != 5'd0);
    return d;
  endfunction

  function automatic trace_rec_t apply_write(input trace_rec_t rec, input reg_write_t wr);
    trace_rec_t res;
    res = rec;
    if (wr.we && rec.dec.rd_used && wr.addr == rec.dec.rd) begin
      res.rd_seen  = 1'b1;
      res.rd_value = wr.wdata;
    end
    return res;
  endfunction

  // one rising edge, with the inputs that were sampled there
  task automatic model_edge();
    trace_rec_t ex_upd;
    trace_rec_t wb_upd;
    logic       dec_evt;
    logic       ex_leave;
    logic       emit;
    logic       adv;
    logic       load;
    dec_evt  = (id_valid && is_decoding) || pipe_flush;
    ex_leave = ex_valid && m_ex_occ;
    emit     = wb_valid && m_wb_occ;
    ex_upd   = apply_write(m_ex, ex_reg);
    if (ex_data.req && ex_data.gnt && !m_ex.mem_obs.valid) begin
      ex_upd.mem_obs.valid = 1'b1;
      ex_upd.mem_obs.we    = ex_data.we;
      ex_upd.mem_obs.addr  = ex_data.addr;
    end
    wb_upd = apply_write(m_wb, wb_reg);
    if (emit) begin
      exp_q.push_back(wb_upd);
      exp_cyc_q.push_back(m_wb_cyc);
    end
    adv  = ex_leave && (!m_wb_occ || emit);
    load = m_armed && dec_evt && (!m_ex_occ || ex_leave);
    if ((ex_leave && !adv) || (m_armed && dec_evt && !load)) begin
      m_ovf = 1'b1;
    end
    if (adv) begin
      m_wb     = ex_upd;
      m_wb_cyc = m_ex_cyc;
      m_wb_occ = 1'b1;
    end else if (emit) begin
      m_wb_occ = 1'b0;
    end else begin
      m_wb = wb_upd;
    end
    if (load) begin
      m_ex           = '0;
      m_ex.pc        = pc;
      m_ex.instr     = instr;
      m_ex.dec       = classify(instr);
      m_ex.rs1_value = rs1_value;
      m_ex.rs2_value = rs2_value;
      m_ex_cyc       = m_cycle;
      m_ex_occ       = 1'b1;
    end else if (ex_leave) begin
      m_ex_occ = 1'b0;
    end else begin
      m_ex = ex_upd;
    end
    if (fetch_enable) begin
      m_armed = 1'b1;
    end
    m_cycle = m_cycle + 1;
  endtask

  ////////////////////
  // checks
  ////////////////////
  task automatic check_val(input string name, input logic [255:0] got,
                           input logic [255:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("Fail %0t ns %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    trace_rec_t             exp_rec;
    logic [CYCLE_WIDTH-1:0] exp_cyc;
    check_val("trace_overflow", 256'(trace_overflow), 256'(m_ovf));
    if (trace_valid) begin
      assert (exp_q.size() != 0) else begin
        other_errors++;
        $display("at %0t ns trace_valid was high but no record was due", $time);
      end
      if (exp_q.size() != 0) begin
        exp_rec = exp_q.pop_front();
        exp_cyc = exp_cyc_q.pop_front();
        n_emitted++;
        check_val("trace_cycle", 256'(trace_cycle), 256'(exp_cyc));
        check_val("trace_rec.pc", 256'(trace_rec.pc), 256'(exp_rec.pc));
        check_val("trace_rec.dec", 256'(trace_rec.dec), 256'(exp_rec.dec));
        check_val("trace_rec", 256'(trace_rec), 256'(exp_rec));
      end
    end
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("at %0t ns a due record was not emitted", $time);
    end
    exp_q.delete();
    exp_cyc_q.delete();
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  task automatic drive_inputs(input int cyc);
    logic [31:0] r;
    logic [7:0]  dec_rate;
    logic [7:0]  ex_rate;
    logic [7:0]  wb_rate;
    dec_rate = (cyc < ARM_CYCLE) ? 8'd128 : (cyc < BURST_CYCLE) ? 8'd48 : 8'd240;
    ex_rate  = (cyc < BURST_CYCLE) ? 8'd200 : 8'd40;
    wb_rate  = ex_rate;
    r = next_rand();
    fetch_enable = (cyc == ARM_CYCLE) || ((cyc > ARM_CYCLE) && r[8]);
    if (r[7:0] < dec_rate) begin
      pipe_flush  = (r[11:9] == 3'd0);
      id_valid    = !pipe_flush;
      is_decoding = !pipe_flush;
    end else begin
      pipe_flush  = 1'b0;
      id_valid    = r[12];
      is_decoding = !r[12] && r[13];
    end
    ex_valid = (r[23:16] < ex_rate);
    wb_valid = (r[31:24] < wb_rate);
    // rd kept in x0..x7 so that writes often hit it
    r         = next_rand();
    instr     = {r[31:12], 2'b00, r[9:7], pick_opcode(r[3:0])};
    pc        = next_rand();
    pc[1:0]   = 2'b00;
    rs1_value = next_rand();
    rs2_value = next_rand();
    r            = next_rand();
    ex_reg.we    = r[0] | r[1];
    ex_reg.addr  = r[2] ? m_ex.dec.rd : {2'b00, r[5:3]};
    ex_reg.wdata = next_rand();
    wb_reg.we    = r[6] | r[7];
    wb_reg.addr  = r[8] ? m_wb.dec.rd : {2'b00, r[11:9]};
    wb_reg.wdata = next_rand();
    ex_data.req  = r[12];
    ex_data.gnt  = r[13];
    ex_data.we   = r[14];
    ex_data.addr = next_rand();
  endtask

  initial begin
    rng          = 32'd26;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    pc           = '0;
    instr        = '0;
    id_valid     = 1'b0;
    is_decoding  = 1'b0;
    pipe_flush   = 1'b0;
    rs1_value    = '0;
    rs2_value    = '0;
    ex_valid     = 1'b0;
    ex_reg       = '0;
    ex_data      = '0;
    wb_valid     = 1'b0;
    wb_reg       = '0;
    m_armed      = 1'b0;
    m_ex_occ     = 1'b0;
    m_wb_occ     = 1'b0;
    m_ovf        = 1'b0;
    m_ex         = '0;
    m_wb         = '0;
    m_ex_cyc     = '0;
    m_wb_cyc     = '0;
    m_cycle      = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    drive_inputs(0);
    for (int cyc = 1; cyc <= NUM_CYCLES; cyc++) begin
      @(posedge clk);
      #1;
      model_edge();
      check_outputs();
      drive_inputs(cyc);
    end
    assert (m_ovf) else begin
      other_errors++;
      $display("burst phase never filled both slots");
    end
    assert (n_emitted > 0) else begin
      other_errors++;
      $display("no record was ever emitted");
    end
    $display("errors: %0d value mismatches, %0d other failures, %0d records checked",
             value_errors, other_errors, n_emitted);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((NUM_CYCLES + RESET_CYCLES + MARGIN) * CLK_PERIOD);
    $display("timeout: stimulus loop did not finish in time");
    $display("errors: %0d value mismatches, %0d other failures, %0d records checked",
             value_errors, other_errors + 1, n_emitted);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_trace.f
common/rv_isa_pkg.sv
common/trace_pkg.sv
source/trace_ctrl.sv
decode/instr_classify.sv
capture/ex_capture.sv
capture/wb_capture.sv
source/trace_top.sv
dv/trace_top_tb.sv

//--- source/trace_ctrl.sv
/*
  arming is one way, only reset returns to idle
  no back-pressure, overflow is sticky
*/
`timescale 1ns/1ps
`default_nettype none

module trace_ctrl #(
  parameter int unsigned CYCLE_WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_enable,
  input  logic                   id_valid,
  input  logic                   is_decoding,
  input  logic                   pipe_flush,
  input  logic                   ex_valid,
  input  logic                   wb_valid,
  output logic                   load_ex,
  output logic                   advance_ex,
  output logic                   emit_wb,
  output logic [CYCLE_WIDTH-1:0] cycle_count,
  output logic                   trace_overflow
);
  import trace_pkg::*;

  ctrl_state_e state_q;
  logic        ex_occ_q;
  logic        wb_occ_q;
  logic        decode_evt;
  logic        ex_leave;
  logic        ex_drop;
  logic        mv_drop;

  ////////////////////
  // strobes
  ////////////////////
  assign decode_evt = (id_valid && is_decoding) || pipe_flush;
  assign ex_leave   = ex_valid && ex_occ_q;
  assign emit_wb    = wb_valid && wb_occ_q;
  // move only lands when WB empties or is free
  assign advance_ex = ex_leave && (!wb_occ_q || emit_wb);
  assign mv_drop    = ex_leave && wb_occ_q && !emit_wb;
  assign load_ex    = (state_q == st_armed) && decode_evt && (!ex_occ_q || ex_leave);
  assign ex_drop    = (state_q == st_armed) && decode_evt && ex_occ_q && !ex_leave;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= st_idle;
      cycle_count    <= '0;
      ex_occ_q       <= 1'b0;
      wb_occ_q       <= 1'b0;
      trace_overflow <= 1'b0;
    end else begin
      if (fetch_enable) begin
        state_q <= st_armed;
      end
      cycle_count <= cycle_count + 1'b1;
      // a dropped move still vacates EX
      ex_occ_q    <= load_ex || (ex_occ_q && !ex_leave);
      wb_occ_q    <= advance_ex || (wb_occ_q && !emit_wb);
      if (ex_drop || mv_drop) begin
        trace_overflow <= 1'b1;
      end
    end
  end

  ////////////////////
  // checks
  ////////////////////
  a_no_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == st_idle) |-> !load_ex);

  a_emit_occupied: assert property (@(posedge clk) disable iff (!rst_n)
    emit_wb |-> wb_occ_q);

endmodule

`default_nettype wire

//--- source/trace_top.sv
/*
  all inputs are plain strobes sampled at the rising edge
  records dropped on overflow are lost, trace_overflow flags it until reset
*/
`timescale 1ns/1ps
`default_nettype none

module trace_top #(
  parameter int unsigned CYCLE_WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_enable,
  input  rv_isa_pkg::word_t      pc,
  input  rv_isa_pkg::word_t      instr,
  input  logic                   id_valid,
  input  logic                   is_decoding,
  input  logic                   pipe_flush,
  input  rv_isa_pkg::word_t      rs1_value,
  input  rv_isa_pkg::word_t      rs2_value,
  input  logic                   ex_valid,
  input  trace_pkg::reg_write_t  ex_reg,
  input  trace_pkg::mem_req_t    ex_data,
  input  logic                   wb_valid,
  input  trace_pkg::reg_write_t  wb_reg,
  output logic                   trace_valid,
  output trace_pkg::trace_rec_t  trace_rec,
  output logic [CYCLE_WIDTH-1:0] trace_cycle,
  output logic                   trace_overflow
);
  import trace_pkg::*;

  dec_info_t              dec;
  trace_rec_t             ex_rec;
  logic [CYCLE_WIDTH-1:0] ex_cycle;
  logic [CYCLE_WIDTH-1:0] cycle_count;
  logic                   load_ex;
  logic                   advance_ex;
  logic                   emit_wb;

  trace_ctrl #(.CYCLE_WIDTH(CYCLE_WIDTH)) trace_ctrl_inst (
    .clk, .rst_n, .fetch_enable, .id_valid, .is_decoding, .pipe_flush,
    .ex_valid, .wb_valid, .load_ex, .advance_ex, .emit_wb, .cycle_count,
    .trace_overflow
  );

  instr_classify instr_classify_inst (
    .instr,
    .dec
  );

  ex_capture #(.CYCLE_WIDTH(CYCLE_WIDTH)) ex_capture_inst (
    .clk, .rst_n, .load_ex, .advance_ex, .dec, .pc, .instr, .rs1_value,
    .rs2_value, .cycle_count, .ex_reg, .ex_data, .ex_rec, .ex_cycle
  );

  wb_capture #(.CYCLE_WIDTH(CYCLE_WIDTH)) wb_capture_inst (
    .clk, .rst_n, .advance_ex, .emit_wb, .ex_rec, .ex_cycle, .wb_reg,
    .trace_valid, .trace_rec, .trace_cycle
  );

endmodule

`default_nettype wire
